//--- hdl/any1_isa_pkg.sv
/*
 * any1 instruction set encoding
 * Data and instruction widths, instruction field positions and the
 * opcode and function encodings seen by the decode stage
 */
package any1_isa_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int INSN_W = 36;
	localparam int WORD_W = 64;
	localparam int REG_W  = 6;

	typedef logic [WORD_W-1:0] Word;
	typedef logic [WORD_W-1:0] Address;

	// Stack pointer, used implicitly by CALL and RTS
	localparam logic [REG_W-1:0] REG_SP = 6'd30;

	// ============================================================
	// Field positions in the instruction word
	// ============================================================
	localparam int OPC_MSB  = 7;
	localparam int OPC_LSB  = 0;
	localparam int RT_MSB   = 13;
	localparam int RT_LSB   = 8;
	localparam int RA_MSB   = 19;
	localparam int RA_LSB   = 14;
	localparam int RB_MSB   = 25;
	localparam int RB_LSB   = 20;
	localparam int FUNC_MSB = 35;
	localparam int FUNC_LSB = 30;
	localparam int IMM_MSB  = 35;
	localparam int IMM_LSB  = 20;
	localparam int JD_MSB   = 35;
	localparam int JD_LSB   = 10;
	localparam int LD_MSB   = 31;
	localparam int LD_LSB   = 20;
	// Upper part of the branch displacement, the rt field supplies the rest
	localparam int BRH_MSB  = 35;
	localparam int BRH_LSB  = 28;

	// ============================================================
	// Opcodes
	// ============================================================
	// R1, R2 and R3 select a function group through the func field
	typedef enum logic [OPC_MSB-OPC_LSB:0] {
		BRK   = 8'h00,
		R1    = 8'h01,
		R2    = 8'h02,
		R3    = 8'h03,
		ADDI  = 8'h04,
		MULI  = 8'h06,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		MULUI = 8'h0E,
		SLTI  = 8'h13,
		SLTUI = 8'h14,
		NOP   = 8'h3F,
		JAL   = 8'h40,
		JALR  = 8'h41,
		CALL  = 8'h42,
		RTS   = 8'h43,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B,
		BLTU  = 8'h4C,
		BGEU  = 8'h4D,
		LDx   = 8'h60,
		LDxX  = 8'h61,
		LEA   = 8'h62,
		STx   = 8'h70,
		STxX  = 8'h71
	} opcode_e;

	// Function codes are unique across the three groups
	typedef enum logic [FUNC_MSB-FUNC_LSB:0] {
		CTLZ  = 6'h00,
		CTPOP = 6'h02,
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		ABS   = 6'h0C,
		NOT   = 6'h0D,
		MUL   = 6'h10,
		MULU  = 6'h11,
		DIV   = 6'h14,
		DIVU  = 6'h15,
		SLL   = 6'h20,
		SRL   = 6'h21,
		SLLI  = 6'h24,
		SRLI  = 6'h25,
		SEQ   = 6'h26,
		SLT   = 6'h28,
		SLTU  = 6'h29,
		CHK   = 6'h30
	} func_e;

endpackage

//--- hdl/any1_decode_pkg.sv
/*
 * any1 decoder formats
 * Encodings that tell the operand generator how to build the
 * immediate and which register numbers to select
 */
package any1_decode_pkg;

	localparam int IMM_FMT_W = 4;
	localparam int RT_FMT_W  = 2;
	localparam int RA_FMT_W  = 1;
	localparam int RC_FMT_W  = 1;

	// Number of rt bits kept for a link register
	localparam int LINK_W = 2;

	// ============================================================
	// Immediate formats
	// ============================================================
	typedef enum logic [IMM_FMT_W-1:0] {
		IMM_NONE  = 4'd0,
		IMM_S16   = 4'd1,
		IMM_Z16   = 4'd2,
		IMM_O16   = 4'd3,
		IMM_SHAMT = 4'd4,
		IMM_J26   = 4'd5,
		IMM_BR    = 4'd6,
		IMM_LD    = 4'd7,
		IMM_ST    = 4'd8
	} imm_fmt_e;

	// ============================================================
	// Register selection formats
	// ============================================================
	typedef enum logic [RT_FMT_W-1:0] {
		RT_NONE  = 2'd0,
		RT_FIELD = 2'd1,
		RT_LINK  = 2'd2,
		RT_SP    = 2'd3
	} rt_fmt_e;

	typedef enum logic [RA_FMT_W-1:0] {
		RA_FIELD = 1'b0,
		RA_SP    = 1'b1
	} ra_fmt_e;

	// Rc is carried in the rt field
	typedef enum logic [RC_FMT_W-1:0] {
		RC_NONE  = 1'b0,
		RC_FIELD = 1'b1
	} rc_fmt_e;

endpackage

//--- hdl/any1_opcode_decode.sv
/*
 * any1 opcode classifier
 * Maps the opcode and function code to the control flags and to the
 * formats used by the operand generator
 */
module any1_opcode_decode
	import any1_isa_pkg::*;
	import any1_decode_pkg::*;
(
	input  logic [INSN_W-1:0] ir,
	output logic              ui,
	output logic              rfwr,
	output logic              mc,
	output logic              is_signed,
	output logic              branch,
	output logic              mem_op,
	output logic              need_ra,
	output logic              need_rb,
	output logic              need_rc,
	output imm_fmt_e          imm_fmt,
	output rt_fmt_e           rt_fmt,
	output ra_fmt_e           ra_fmt,
	output rc_fmt_e           rc_fmt
);

	opcode_e opcode;
	func_e   func;

	assign opcode = opcode_e'(ir[OPC_MSB:OPC_LSB]);
	assign func   = func_e'(ir[FUNC_MSB:FUNC_LSB]);

	always_comb begin
		// Anything not matched below stays unimplemented
		ui        = 1'b1;
		rfwr      = 1'b0;
		mc        = 1'b0;
		is_signed = 1'b1;
		branch    = 1'b0;
		mem_op    = 1'b0;
		need_ra   = 1'b1;
		need_rb   = 1'b0;
		need_rc   = 1'b0;
		imm_fmt   = IMM_NONE;
		rt_fmt    = RT_NONE;
		ra_fmt    = RA_FIELD;
		rc_fmt    = RC_NONE;

		case (opcode)
			BRK, NOP: ui = 1'b0;
			R1: begin
				case (func)
					ABS, NOT, CTLZ, CTPOP: begin
						ui     = 1'b0;
						rfwr   = 1'b1;
						rt_fmt = RT_FIELD;
					end
					default: ;
				endcase
			end
			R2: begin
				need_rb = 1'b1;
				case (func)
					ADD, SUB, AND, OR, XOR, SLL, SRL, SEQ, SLT, SLTU,
					SLLI, SRLI, MUL, MULU, DIV, DIVU: begin
						ui     = 1'b0;
						rfwr   = 1'b1;
						rt_fmt = RT_FIELD;
					end
					default: ;
				endcase
				// Shift amount and multi-cycle or unsigned forms within the group
				case (func)
					SLLI, SRLI: imm_fmt = IMM_SHAMT;
					MUL, DIV: mc = 1'b1;
					MULU, DIVU: begin
						mc        = 1'b1;
						is_signed = 1'b0;
					end
					SLTU: is_signed = 1'b0;
					default: ;
				endcase
			end
			R3: begin
				need_rb = 1'b1;
				if (func == CHK) begin
					ui      = 1'b0;
					need_rc = 1'b1;
					rc_fmt  = RC_FIELD;
				end
			end
			ADDI, SLTI, MULI, ORI, XORI, SLTUI, MULUI, ANDI: begin
				ui      = 1'b0;
				rfwr    = 1'b1;
				rt_fmt  = RT_FIELD;
				imm_fmt = (opcode == ANDI) ? IMM_O16 :
				          (opcode inside {ADDI, SLTI, MULI}) ? IMM_S16 : IMM_Z16;
				mc        = opcode inside {MULI, MULUI};
				is_signed = !(opcode inside {SLTUI, MULUI});
			end
			JAL, JALR, CALL, RTS: begin
				ui      = 1'b0;
				rfwr    = 1'b1;
				mc      = 1'b1;
				need_ra = !(opcode inside {JAL, CALL});
				imm_fmt = (opcode inside {JAL, CALL}) ? IMM_J26 : IMM_S16;
				if (opcode inside {CALL, RTS}) begin
					rt_fmt = RT_SP;
					ra_fmt = RA_SP;
				end else begin
					rt_fmt = RT_LINK;
				end
			end
			BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
				ui        = 1'b0;
				branch    = 1'b1;
				mc        = 1'b1;
				need_rb   = 1'b1;
				imm_fmt   = IMM_BR;
				is_signed = !(opcode inside {BLTU, BGEU});
			end
			LDx, LDxX, LEA: begin
				ui      = 1'b0;
				rfwr    = 1'b1;
				mc      = 1'b1;
				mem_op  = 1'b1;
				rt_fmt  = RT_FIELD;
				need_rb = (opcode == LDxX);
				imm_fmt = (opcode == LDxX) ? IMM_NONE : IMM_LD;
			end
			STx, STxX: begin
				ui      = 1'b0;
				mc      = 1'b1;
				mem_op  = 1'b1;
				need_rb = 1'b1;
				imm_fmt = (opcode == STx) ? IMM_ST : IMM_NONE;
			end
			default: ;
		endcase

		// Branches and CHK only read registers, so the table never pairs them with a write
		assert (!(rfwr && branch))
			else $error("decode: branch marked as register writer, ir=%h", ir);
		assert (!need_rc || !rfwr)
			else $error("decode: CHK form marked as register writer, ir=%h", ir);
	end

endmodule

//--- hdl/any1_operand_gen.sv
/*
 * any1 operand generator
 * Selects register numbers and builds the 64-bit immediate from the
 * instruction fields according to the decoded formats
 */
module any1_operand_gen
	import any1_isa_pkg::*;
	import any1_decode_pkg::*;
(
	input  logic [INSN_W-1:0] ir,
	input  imm_fmt_e          imm_fmt,
	input  rt_fmt_e           rt_fmt,
	input  ra_fmt_e           ra_fmt,
	input  rc_fmt_e           rc_fmt,
	output logic [REG_W-1:0]  ra,
	output logic [REG_W-1:0]  rb,
	output logic [REG_W-1:0]  rc,
	output logic [REG_W-1:0]  rt,
	output Word               imm
);

	logic [REG_W-1:0]       rt_field;
	logic [IMM_MSB:IMM_LSB] imm16;
	logic [JD_MSB:JD_LSB]   jdisp;
	logic [LD_MSB:LD_LSB]   ld_disp;
	// Split displacements, high bits on top of the rt field
	logic [BRH_MSB-BRH_LSB+REG_W:0]   br_disp;
	logic [FUNC_MSB-FUNC_LSB+REG_W:0] st_disp;

	assign rt_field = ir[RT_MSB:RT_LSB];
	assign imm16    = ir[IMM_MSB:IMM_LSB];
	assign jdisp    = ir[JD_MSB:JD_LSB];
	assign ld_disp  = ir[LD_MSB:LD_LSB];
	assign br_disp  = {ir[BRH_MSB:BRH_LSB], rt_field};
	assign st_disp  = {ir[FUNC_MSB:FUNC_LSB], rt_field};

	// ============================================================
	// Register numbers
	// ============================================================
	assign rb = ir[RB_MSB:RB_LSB];
	assign ra = (ra_fmt == RA_SP) ? REG_SP : ir[RA_MSB:RA_LSB];
	assign rc = (rc_fmt == RC_FIELD) ? rt_field : '0;

	always_comb begin
		case (rt_fmt)
			RT_FIELD: rt = rt_field;
			// Only the low link register bits survive
			RT_LINK:  rt = {{(REG_W-LINK_W){1'b0}}, rt_field[LINK_W-1:0]};
			RT_SP:    rt = REG_SP;
			default:  rt = '0;
		endcase
	end

	// ============================================================
	// Immediate
	// ============================================================
	// A size cast of a signed value sign-extends it to the word width
	always_comb begin
		case (imm_fmt)
			IMM_S16:   imm = Word'(signed'(imm16));
			IMM_Z16:   imm = Word'(imm16);
			IMM_O16:   imm = {{(WORD_W-$bits(imm16)){1'b1}}, imm16};
			IMM_SHAMT: imm = Word'(rb);
			IMM_J26:   imm = Word'(signed'(jdisp));
			IMM_BR:    imm = Word'(signed'(br_disp));
			IMM_LD:    imm = Word'(signed'(ld_disp));
			IMM_ST:    imm = Word'(signed'(st_disp));
			default:   imm = '0;
		endcase
	end

endmodule

//--- hdl/any1_decode_buf.sv
/*
 * any1 decode buffer
 * Registers the decode record with the instruction address and
 * prediction, one cycle after the word was presented
 */
module any1_decode_buf
	import any1_isa_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             a2d_valid,
	input  Address           a2d_ip,
	input  Address           a2d_predicted_ip,
	input  logic             a2d_predict_taken,
	input  logic             ui,
	input  logic             rfwr,
	input  logic             mc,
	input  logic             is_signed,
	input  logic             branch,
	input  logic             mem_op,
	input  logic             need_ra,
	input  logic             need_rb,
	input  logic             need_rc,
	input  logic [REG_W-1:0] ra,
	input  logic [REG_W-1:0] rb,
	input  logic [REG_W-1:0] rc,
	input  logic [REG_W-1:0] rt,
	input  Word              imm,
	output logic             dec_valid,
	output Address           dec_ip,
	output Address           dec_pip,
	output logic             dec_predict_taken,
	output logic             dec_ui,
	output logic             dec_rfwr,
	output logic             dec_mc,
	output logic             dec_is_signed,
	output logic             dec_branch,
	output logic             dec_mem_op,
	output logic             dec_need_ra,
	output logic             dec_need_rb,
	output logic             dec_need_rc,
	output logic [REG_W-1:0] dec_ra,
	output logic [REG_W-1:0] dec_rb,
	output logic [REG_W-1:0] dec_rc,
	output logic [REG_W-1:0] dec_rt,
	output Word              dec_imm
);

	// Control state that later stages act on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid  <= 1'b0;
			dec_ui     <= 1'b0;
			dec_rfwr   <= 1'b0;
			dec_mc     <= 1'b0;
			dec_branch <= 1'b0;
			dec_mem_op <= 1'b0;
		end else begin
			dec_valid  <= a2d_valid;
			dec_ui     <= ui;
			dec_rfwr   <= rfwr;
			dec_mc     <= mc;
			dec_branch <= branch;
			dec_mem_op <= mem_op;
		end
	end

	// Payload is captured every cycle and qualified by dec_valid
	always_ff @(posedge clk) begin
		dec_ip            <= a2d_ip;
		dec_pip           <= a2d_predicted_ip;
		dec_predict_taken <= a2d_predict_taken;
		dec_is_signed     <= is_signed;
		dec_need_ra       <= need_ra;
		dec_need_rb       <= need_rb;
		dec_need_rc       <= need_rc;
		dec_ra            <= ra;
		dec_rb            <= rb;
		dec_rc            <= rc;
		dec_rt            <= rt;
		dec_imm           <= imm;
	end

	// No record survives a reset edge
	assert property (@(posedge clk) !rst_n |=> !dec_valid);

	// An unimplemented instruction must not reach writeback or the multi-cycle units
	assert property (@(posedge clk) disable iff (!rst_n) dec_ui |-> !dec_rfwr && !dec_mc);

endmodule

//--- hdl/any1_decode_top.sv
/*
 * any1 decode stage
 * Classifies the instruction, extracts its operands and registers
 * the decode record
 */
module any1_decode_top
	import any1_isa_pkg::*;
	import any1_decode_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              a2d_valid,
	input  logic [INSN_W-1:0] a2d_ir,
	input  Address            a2d_ip,
	input  Address            a2d_predicted_ip,
	input  logic              a2d_predict_taken,
	output logic              dec_valid,
	output Address            dec_ip,
	output Address            dec_pip,
	output logic              dec_predict_taken,
	output logic [REG_W-1:0]  dec_ra,
	output logic [REG_W-1:0]  dec_rb,
	output logic [REG_W-1:0]  dec_rc,
	output logic [REG_W-1:0]  dec_rt,
	output Word               dec_imm,
	output logic              dec_ui,
	output logic              dec_rfwr,
	output logic              dec_mc,
	output logic              dec_is_signed,
	output logic              dec_branch,
	output logic              dec_mem_op,
	output logic              dec_need_ra,
	output logic              dec_need_rb,
	output logic              dec_need_rc
);

	logic             ui;
	logic             rfwr;
	logic             mc;
	logic             is_signed;
	logic             branch;
	logic             mem_op;
	logic             need_ra;
	logic             need_rb;
	logic             need_rc;
	imm_fmt_e         imm_fmt;
	rt_fmt_e          rt_fmt;
	ra_fmt_e          ra_fmt;
	rc_fmt_e          rc_fmt;
	logic [REG_W-1:0] ra;
	logic [REG_W-1:0] rb;
	logic [REG_W-1:0] rc;
	logic [REG_W-1:0] rt;
	Word              imm;

	any1_opcode_decode i_any1_opcode_decode (
		.ir        (a2d_ir),
		.ui        (ui),
		.rfwr      (rfwr),
		.mc        (mc),
		.is_signed (is_signed),
		.branch    (branch),
		.mem_op    (mem_op),
		.need_ra   (need_ra),
		.need_rb   (need_rb),
		.need_rc   (need_rc),
		.imm_fmt   (imm_fmt),
		.rt_fmt    (rt_fmt),
		.ra_fmt    (ra_fmt),
		.rc_fmt    (rc_fmt)
	);

	any1_operand_gen i_any1_operand_gen (
		.ir      (a2d_ir),
		.imm_fmt (imm_fmt),
		.rt_fmt  (rt_fmt),
		.ra_fmt  (ra_fmt),
		.rc_fmt  (rc_fmt),
		.ra      (ra),
		.rb      (rb),
		.rc      (rc),
		.rt      (rt),
		.imm     (imm)
	);

	any1_decode_buf i_any1_decode_buf (
		.clk               (clk),
		.rst_n             (rst_n),
		.a2d_valid         (a2d_valid),
		.a2d_ip            (a2d_ip),
		.a2d_predicted_ip  (a2d_predicted_ip),
		.a2d_predict_taken (a2d_predict_taken),
		.ui                (ui),
		.rfwr              (rfwr),
		.mc                (mc),
		.is_signed         (is_signed),
		.branch            (branch),
		.mem_op            (mem_op),
		.need_ra           (need_ra),
		.need_rb           (need_rb),
		.need_rc           (need_rc),
		.ra                (ra),
		.rb                (rb),
		.rc                (rc),
		.rt                (rt),
		.imm               (imm),
		.dec_valid         (dec_valid),
		.dec_ip            (dec_ip),
		.dec_pip           (dec_pip),
		.dec_predict_taken (dec_predict_taken),
		.dec_ui            (dec_ui),
		.dec_rfwr          (dec_rfwr),
		.dec_mc            (dec_mc),
		.dec_is_signed     (dec_is_signed),
		.dec_branch        (dec_branch),
		.dec_mem_op        (dec_mem_op),
		.dec_need_ra       (dec_need_ra),
		.dec_need_rb       (dec_need_rb),
		.dec_need_rc       (dec_need_rc),
		.dec_ra            (dec_ra),
		.dec_rb            (dec_rb),
		.dec_rc            (dec_rc),
		.dec_rt            (dec_rt),
		.dec_imm           (dec_imm)
	);

endmodule

//--- tests/any1_decode_model.svh
/*
 * any1 decode reference model
 * Expected decode record for one instruction word, derived from the
 * instruction set rules
 */
`ifndef ANY1_DECODE_MODEL_SVH
`define ANY1_DECODE_MODEL_SVH

import any1_isa_pkg::*;
import any1_decode_pkg::*;

typedef struct packed {
	logic             ui;
	logic             rfwr;
	logic             mc;
	logic             is_signed;
	logic             branch;
	logic             mem_op;
	logic             need_ra;
	logic             need_rb;
	logic             need_rc;
	logic [REG_W-1:0] ra;
	logic [REG_W-1:0] rb;
	logic [REG_W-1:0] rc;
	logic [REG_W-1:0] rt;
	Word              imm;
} decode_rec_t;

// For the register groups the function code decides as well
function automatic logic insn_kept(input logic [7:0] opc, input logic [5:0] fn);
	case (opc)
		R1: return fn inside {ABS, NOT, CTLZ, CTPOP};
		R2: return fn inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SLLI, SRLI,
		                      MUL, MULU, DIV, DIVU, SEQ, SLT, SLTU};
		R3: return fn == CHK;
		default: return opc inside {BRK, NOP, ADDI, ANDI, ORI, XORI, MULI, MULUI,
		                            SLTI, SLTUI, JAL, JALR, CALL, RTS, BEQ, BNE,
		                            BLT, BGE, BLTU, BGEU, LDx, LDxX, LEA, STx, STxX};
	endcase
endfunction

function automatic imm_fmt_e imm_format_of(input logic [7:0] opc, input logic [5:0] fn);
	case (opc)
		ADDI, MULI, SLTI, JALR, RTS:    return IMM_S16;
		ORI, XORI, MULUI, SLTUI:        return IMM_Z16;
		ANDI:                           return IMM_O16;
		JAL, CALL:                      return IMM_J26;
		BEQ, BNE, BLT, BGE, BLTU, BGEU: return IMM_BR;
		LDx, LEA:                       return IMM_LD;
		STx:                            return IMM_ST;
		R2:      return (fn inside {SLLI, SRLI}) ? IMM_SHAMT : IMM_NONE;
		default: return IMM_NONE;
	endcase
endfunction

// Explicit extension of each displacement to the full word
function automatic Word build_imm(input logic [INSN_W-1:0] ir, input imm_fmt_e fmt);
	logic [15:0] i16;
	logic [25:0] jd;
	logic [11:0] ld;
	logic [13:0] br;
	logic [11:0] st;
	i16 = ir[35:20];
	jd  = ir[35:10];
	ld  = ir[31:20];
	br  = {ir[35:28], ir[13:8]};
	st  = {ir[35:30], ir[13:8]};
	case (fmt)
		IMM_S16:   return {{48{i16[15]}}, i16};
		IMM_Z16:   return {48'd0, i16};
		IMM_O16:   return {{48{1'b1}}, i16};
		IMM_SHAMT: return {58'd0, ir[25:20]};
		IMM_J26:   return {{38{jd[25]}}, jd};
		IMM_BR:    return {{50{br[13]}}, br};
		IMM_LD:    return {{52{ld[11]}}, ld};
		IMM_ST:    return {{52{st[11]}}, st};
		default:   return '0;
	endcase
endfunction

function automatic decode_rec_t predict_decode(input logic [INSN_W-1:0] ir);
	decode_rec_t      r;
	logic [7:0]       opc;
	logic [5:0]       fn;
	logic [REG_W-1:0] rt_f;
	imm_fmt_e         fmt;
	opc  = ir[OPC_MSB:OPC_LSB];
	fn   = ir[FUNC_MSB:FUNC_LSB];
	rt_f = ir[RT_MSB:RT_LSB];
	fmt  = IMM_NONE;
	r    = '0;
	r.ui        = !insn_kept(opc, fn);
	r.is_signed = 1'b1;
	r.need_ra   = 1'b1;
	r.ra        = ir[RA_MSB:RA_LSB];
	r.rb        = ir[RB_MSB:RB_LSB];
	// The register groups read Rb even when the function is unknown
	r.need_rb   = opc inside {R2, R3, BEQ, BNE, BLT, BGE, BLTU, BGEU, LDxX, STx, STxX};
	if (!r.ui) begin
		r.rfwr = opc inside {R1, R2, ADDI, ANDI, ORI, XORI, MULI, MULUI, SLTI, SLTUI,
		                     JAL, JALR, CALL, RTS, LDx, LDxX, LEA};
		r.mc = (opc == R2 && fn inside {MUL, MULU, DIV, DIVU}) ||
		       opc inside {MULI, MULUI, JAL, JALR, CALL, RTS, BEQ, BNE, BLT, BGE,
		                   BLTU, BGEU, LDx, LDxX, LEA, STx, STxX};
		r.is_signed = !((opc == R2 && fn inside {SLTU, MULU, DIVU}) ||
		                opc inside {MULUI, SLTUI, BLTU, BGEU});
		r.branch  = opc inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
		r.mem_op  = opc inside {LDx, LDxX, LEA, STx, STxX};
		r.need_ra = !(opc inside {JAL, CALL});
		r.need_rc = (opc == R3);
		if (opc inside {JAL, JALR})
			r.rt = {{(REG_W-2){1'b0}}, rt_f[1:0]};
		else if (opc inside {CALL, RTS})
			r.rt = 6'd30;
		else if (r.rfwr)
			r.rt = rt_f;
		if (opc inside {CALL, RTS})
			r.ra = 6'd30;
		if (r.need_rc)
			r.rc = rt_f;
		fmt = imm_format_of(opc, fn);
	end
	r.imm = build_imm(ir, fmt);
	return r;
endfunction

`endif

//--- tests/tb_any1_decode.sv
/*
 * any1 decode stage testbench
 * Random instruction stream checked against the reference model,
 * plus reset behavior and one-cycle latency
 */
`include "any1_decode_model.svh"

module tb_any1_decode
	import any1_isa_pkg::*;
	import any1_decode_pkg::*;
();

	localparam int CLK_PERIOD  = 20;
	localparam int TOTAL_ITEMS = 400;

	localparam opcode_e KEPT_OPS [28] = '{BRK, R1, R2, R3, ADDI, MULI, ANDI, ORI, XORI,
		MULUI, SLTI, SLTUI, NOP, JAL, JALR, CALL, RTS, BEQ, BNE, BLT, BGE, BLTU, BGEU,
		LDx, LDxX, LEA, STx, STxX};
	localparam func_e R1_FUNCS [4] = '{ABS, NOT, CTLZ, CTPOP};
	localparam func_e R2_FUNCS [16] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SLLI, SRLI,
		MUL, MULU, DIV, DIVU, SEQ, SLT, SLTU};

	typedef struct packed {
		logic [INSN_W-1:0] ir;
		Address            ip;
		Address            pip;
		logic              taken;
		int unsigned       stamp;
	} item_t;

	logic              clk;
	logic              rst_n;
	logic              a2d_valid;
	logic [INSN_W-1:0] a2d_ir;
	Address            a2d_ip;
	Address            a2d_predicted_ip;
	logic              a2d_predict_taken;
	logic              dec_valid;
	Address            dec_ip;
	Address            dec_pip;
	logic              dec_predict_taken;
	logic [REG_W-1:0]  dec_ra;
	logic [REG_W-1:0]  dec_rb;
	logic [REG_W-1:0]  dec_rc;
	logic [REG_W-1:0]  dec_rt;
	Word               dec_imm;
	logic              dec_ui;
	logic              dec_rfwr;
	logic              dec_mc;
	logic              dec_is_signed;
	logic              dec_branch;
	logic              dec_mem_op;
	logic              dec_need_ra;
	logic              dec_need_rb;
	logic              dec_need_rc;

	logic [31:0] lcg_state = 32'h4b70a667;
	int unsigned cycle = 0;
	int          errors = 0;
	int          checked = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	item_t       pending [$];

	any1_decode_top i_any1_decode_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ============================================================
	// Random stimulus
	// ============================================================
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// The low LCG bits repeat quickly, so draw from the upper ones
	function automatic int below(input int n);
		return int'((next_rand() >> 8) % n);
	endfunction

	function automatic logic chance(input int pct);
		return below(100) < pct;
	endfunction

	function automatic logic [INSN_W-1:0] make_insn();
		logic [INSN_W-1:0] ir;
		logic [7:0]        opc;
		logic [5:0]        fn;
		ir  = INSN_W'({next_rand(), next_rand()});
		opc = chance(75) ? KEPT_OPS[5'(below(28))] : ir[OPC_MSB:OPC_LSB];
		fn  = ir[FUNC_MSB:FUNC_LSB];
		if (chance(75)) begin
			case (opc)
				R1:      fn = R1_FUNCS[2'(below(4))];
				R2:      fn = R2_FUNCS[4'(below(16))];
				R3:      fn = CHK;
				default: ;
			endcase
		end
		ir[OPC_MSB:OPC_LSB]   = opc;
		ir[FUNC_MSB:FUNC_LSB] = fn;
		return ir;
	endfunction

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_word(input string name, input Word got, input Word exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_W-1:0] got,
	                         input logic [REG_W-1:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input Address got, input Address exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// ============================================================
	// Output checker
	// ============================================================
	// An item driven after edge c is sampled at edge c+1 and seen here with cycle at c+2
	always @(negedge clk) begin : check_output
		item_t       it;
		decode_rec_t exp;
		if (rst_n) begin
			if (dec_valid && pending.size() == 0) begin
				$display("At %0t dec_valid rose with no instruction outstanding", $time);
				errors++;
			end else if (dec_valid) begin
				it  = pending.pop_front();
				exp = predict_decode(it.ir);
				checked++;
				if (cycle != it.stamp + 32'd2) begin
					$display("At %0t ir %h came out after the wrong number of cycles",
					         $time, it.ir);
					errors++;
				end
				check_addr("dec_ip", dec_ip, it.ip);
				check_addr("dec_pip", dec_pip, it.pip);
				check_flag("dec_predict_taken", dec_predict_taken, it.taken);
				check_flag("dec_ui", dec_ui, exp.ui);
				check_flag("dec_rfwr", dec_rfwr, exp.rfwr);
				check_flag("dec_mc", dec_mc, exp.mc);
				check_flag("dec_is_signed", dec_is_signed, exp.is_signed);
				check_flag("dec_branch", dec_branch, exp.branch);
				check_flag("dec_mem_op", dec_mem_op, exp.mem_op);
				check_flag("dec_need_ra", dec_need_ra, exp.need_ra);
				check_flag("dec_need_rb", dec_need_rb, exp.need_rb);
				check_flag("dec_need_rc", dec_need_rc, exp.need_rc);
				check_reg("dec_ra", dec_ra, exp.ra);
				check_reg("dec_rb", dec_rb, exp.rb);
				check_reg("dec_rc", dec_rc, exp.rc);
				check_reg("dec_rt", dec_rt, exp.rt);
				check_word("dec_imm", dec_imm, exp.imm);
			end else if (pending.size() != 0 && cycle >= pending[0].stamp + 32'd2) begin
				$display("At %0t the record for ir %h never appeared", $time, pending[0].ir);
				errors++;
				void'(pending.pop_front());
			end
		end
	end

	// ============================================================
	// Tests
	// ============================================================
	task automatic finish_test(input string name, input int items, input int err_before);
		tests_run++;
		if (errors != err_before)
			tests_bad++;
		$display("Test %-16s %4d items, %0d errors", name, items, errors - err_before);
	endtask

	task automatic expect_reset_state();
		check_flag("dec_valid", dec_valid, 1'b0);
		check_flag("dec_ui", dec_ui, 1'b0);
		check_flag("dec_rfwr", dec_rfwr, 1'b0);
		check_flag("dec_mc", dec_mc, 1'b0);
		check_flag("dec_branch", dec_branch, 1'b0);
		check_flag("dec_mem_op", dec_mem_op, 1'b0);
	endtask

	// Valid words offered during reset must not leak into the record
	task automatic run_reset_test();
		int err_before;
		err_before = errors;
		// A load and then a branch would raise the control flags if reset let them through
		a2d_valid <= 1'b1;
		a2d_ir    <= {28'(next_rand()), LDx};
		@(posedge clk);
		a2d_ir    <= {28'(next_rand()), BEQ};
		@(negedge clk);
		expect_reset_state();
		@(posedge clk);
		rst_n     <= 1'b1;
		a2d_valid <= 1'b0;
		@(negedge clk);
		expect_reset_state();
		@(negedge clk);
		check_flag("dec_valid", dec_valid, 1'b0);
		finish_test("reset", 0, err_before);
	endtask

	task automatic run_random_test(input string name, input int items, input int valid_pct);
		int    err_before;
		item_t it;
		logic  v;
		err_before = errors;
		for (int i = 0; i < items; i++) begin
			@(posedge clk);
			it.ir    = make_insn();
			it.ip    = {next_rand(), next_rand()};
			it.pip   = {next_rand(), next_rand()};
			it.taken = chance(50);
			it.stamp = cycle;
			v        = chance(valid_pct);
			a2d_valid         <= v;
			a2d_ir            <= it.ir;
			a2d_ip            <= it.ip;
			a2d_predicted_ip  <= it.pip;
			a2d_predict_taken <= it.taken;
			if (v)
				pending.push_back(it);
		end
		@(posedge clk);
		a2d_valid <= 1'b0;
		while (pending.size() != 0)
			@(negedge clk);
		finish_test(name, items, err_before);
	endtask

	initial begin
		rst_n             <= 1'b0;
		a2d_valid         <= 1'b0;
		a2d_ir            <= '0;
		a2d_ip            <= '0;
		a2d_predicted_ip  <= '0;
		a2d_predict_taken <= 1'b0;
		run_reset_test();
		run_random_test("flag_table", 120, 80);
		run_random_test("register_numbers", 100, 80);
		run_random_test("immediates", 100, 80);
		run_random_test("passthrough", 80, 100);
		$display("%0d tests, %0d with errors, %0d records checked, %0d errors",
		         tests_run, tests_bad, checked, errors);
		if (errors == 0 && tests_bad == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		#(2 * TOTAL_ITEMS * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+tests
hdl/any1_isa_pkg.sv
hdl/any1_decode_pkg.sv
hdl/any1_opcode_decode.sv
hdl/any1_operand_gen.sv
hdl/any1_decode_buf.sv
hdl/any1_decode_top.sv
tests/tb_any1_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the any1 decode testbench with Verilator, run it and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_any1_decode -Mdir obj_dir -f flist.f \
	&& ./obj_dir/Vtb_any1_decode 2>&1 | tee sim.log \
	|| { echo "Verilator build or simulation run did not complete"; exit 1; }

grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
